//--- hdl/lsq_params.svh
// load/store queue sizing macros for queue depth, ids, data and memory
`ifndef LSQ_PARAMS_SVH
`define LSQ_PARAMS_SVH

// queue depth, id 15 stays free as the "no entry" code
`define LSQ_DEPTH 15
`define LSQ_ID_W 4

// address and data words
`define LSQ_DATA_W 32

// writeback register tag and predicate tag
`define LSQ_TAG_W 4

// data memory, word i comes out of reset holding i
`define DMEM_WORDS 1024
`define DMEM_ADDR_LSB 2 // byte address -> word index

`endif

//--- hdl/lsq_pkg.sv
// load/store queue types for ids, words, core requests, memory traffic and retirement
`include "lsq_params.svh"

package lsq_pkg;

  typedef logic [`LSQ_ID_W-1:0]   lsq_id_t;  // request id == queue slot
  typedef logic [`LSQ_DATA_W-1:0] word_t;    // address or data
  typedef logic [`LSQ_TAG_W-1:0]  reg_tag_t; // wb reg or predicate tag

  // core -> queue, sampled on mem_r / mem_w
  typedef struct packed {
    word_t    addr;
    word_t    data; // store data, ignored for loads
    reg_tag_t wb;
    reg_tag_t z;
  } core_req_t;

  // queue -> memory
  typedef struct packed {
    logic    valid;
    logic    rw;    // 1 = store
    lsq_id_t id;
    word_t   addr;
    word_t   data;
  } mem_req_t;

  // memory -> queue, answers may come back out of order
  typedef struct packed {
    logic    valid;
    lsq_id_t id;
    word_t   data;  // load data, zero for stores
  } mem_rsp_t;

  // queue -> core on ready_out
  typedef struct packed {
    word_t    data;
    reg_tag_t wb;
    reg_tag_t z;
  } retire_t;

  // store to load forwarding result
  typedef struct packed {
    logic  hit;
    word_t data;
  } fwd_hit_t;

endpackage

//--- hdl/lsq_store_fwd.sv
// store forwarding search, youngest valid queued store at the incoming load address
`timescale 1ns/1ps
`include "lsq_params.svh"

module lsq_store_fwd (
  input  lsq_pkg::word_t                   load_addr,
  input  logic [`LSQ_DEPTH-1:0]            entry_valid,
  input  logic [`LSQ_DEPTH-1:0]            entry_store,
  input  lsq_pkg::word_t [`LSQ_DEPTH-1:0]  entry_addr,
  input  lsq_pkg::word_t [`LSQ_DEPTH-1:0]  entry_data,
  input  lsq_pkg::lsq_id_t                 head,
  input  lsq_pkg::lsq_id_t                 tail,
  output lsq_pkg::fwd_hit_t                fwd
);

  logic [`LSQ_DEPTH-1:0] cand; // valid stores at the load address, by slot

  always_comb begin
    for (int i = 0; i < `LSQ_DEPTH; i++) begin
      cand[i] = entry_valid[i] & entry_store[i] & (entry_addr[i] == load_addr);
    end
  end

  // walk oldest to youngest starting at head
  // a later match overwrites an earlier one, so the youngest store wins
  always_comb begin
    int   pos;
    logic live;
    pos  = int'(head);
    live = 1'b1;
    fwd  = '0;
    for (int k = 0; k < `LSQ_DEPTH; k++) begin
      // tail is the first free slot, nothing past it belongs to the queue
      // head == tail at k == 0 is either empty or full, keep scanning
      if ((k != 0) && (pos == int'(tail))) begin
        live = 1'b0;
      end
      if (live && cand[pos]) begin
        fwd.hit  = 1'b1;
        fwd.data = entry_data[pos]; // store data sits in the entry
      end
      pos = (pos == `LSQ_DEPTH - 1) ? 0 : pos + 1; // wrap at queue depth
    end
  end

endmodule

//--- hdl/lsq_queue.sv
// load/store queue, 15-entry circular buffer with forwarding, memory issue and in-order retire
`timescale 1ns/1ps
`include "lsq_params.svh"

module lsq_queue (
  input  logic               clk,
  input  logic               rst,
  input  logic               mem_r,    // load strobe
  input  logic               mem_w,    // store strobe
  input  lsq_pkg::core_req_t core_req,
  input  lsq_pkg::mem_rsp_t  mem_rsp,
  output lsq_pkg::mem_req_t  mem_req,
  output lsq_pkg::retire_t   retire,
  output logic               ready_out,
  output logic               full,
  output logic               empty
);

  // per-slot state
  logic [`LSQ_DEPTH-1:0]              ent_valid;
  logic [`LSQ_DEPTH-1:0]              ent_store; // 1 = store
  logic [`LSQ_DEPTH-1:0]              ent_ready; // data known, may retire
  lsq_pkg::word_t [`LSQ_DEPTH-1:0]    ent_addr;
  lsq_pkg::word_t [`LSQ_DEPTH-1:0]    ent_data;
  lsq_pkg::reg_tag_t [`LSQ_DEPTH-1:0] ent_wb;
  lsq_pkg::reg_tag_t [`LSQ_DEPTH-1:0] ent_z;

  lsq_pkg::lsq_id_t     head;  // oldest entry
  lsq_pkg::lsq_id_t     tail;  // next free slot
  logic [`LSQ_ID_W-1:0] count; // occupancy, 0..15

  lsq_pkg::fwd_hit_t fwd;
  logic              enq;      // request accepted this cycle
  logic              fwd_load; // load served from a queued store
  logic              issue;    // request goes out to memory
  logic              deq;      // head leaves this cycle

  // memory issue register
  logic             issue_valid;
  logic             issue_rw;
  lsq_pkg::lsq_id_t issue_id;
  lsq_pkg::word_t   issue_addr;
  lsq_pkg::word_t   issue_data;

  function automatic lsq_pkg::lsq_id_t next_ptr(input lsq_pkg::lsq_id_t p);
    return (p == lsq_pkg::lsq_id_t'(`LSQ_DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  lsq_store_fwd u_fwd (
    .load_addr   (core_req.addr),
    .entry_valid (ent_valid),
    .entry_store (ent_store),
    .entry_addr  (ent_addr),
    .entry_data  (ent_data),
    .head        (head),
    .tail        (tail),
    .fwd         (fwd)
  );

  assign enq      = (mem_r | mem_w) & ~full; // request while full is dropped
  assign fwd_load = mem_r & fwd.hit;
  assign issue    = enq & ~fwd_load;
  assign deq      = ent_valid[head] & ent_ready[head];

  assign full  = (count == `LSQ_DEPTH);
  assign empty = (count == 0);

  // control state
  always_ff @(posedge clk) begin
    if (rst) begin
      ent_valid   <= '0;
      ent_ready   <= '0;
      head        <= '0;
      tail        <= '0;
      count       <= '0;
      issue_valid <= 1'b0;
      ready_out   <= 1'b0;
    end else begin
      issue_valid <= issue; // one pulse per issued request
      ready_out   <= deq;
      if (enq) begin
        ent_valid[tail] <= 1'b1;
        ent_ready[tail] <= fwd_load; // forwarded loads skip memory
        tail            <= next_ptr(tail);
      end
      if (mem_rsp.valid) begin
        ent_ready[mem_rsp.id] <= 1'b1;
      end
      if (deq) begin
        ent_valid[head] <= 1'b0;
        head            <= next_ptr(head);
      end
      case ({enq, deq})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: ; // both or neither, no change
      endcase
    end
  end

  // entry payload, issue and retire data
  always_ff @(posedge clk) begin
    if (enq) begin
      ent_store[tail] <= mem_w;
      ent_addr[tail]  <= core_req.addr;
      ent_data[tail]  <= fwd_load ? fwd.data : core_req.data;
      ent_wb[tail]    <= core_req.wb;
      ent_z[tail]     <= core_req.z;
      issue_rw        <= mem_w;
      issue_id        <= tail; // slot doubles as request id
      issue_addr      <= core_req.addr;
      issue_data      <= core_req.data;
    end
    if (mem_rsp.valid && !ent_store[mem_rsp.id]) begin
      ent_data[mem_rsp.id] <= mem_rsp.data; // load data back from memory
    end
    retire <= '{data: ent_data[head], wb: ent_wb[head], z: ent_z[head]};
  end

  assign mem_req = '{valid: issue_valid, rw: issue_rw, id: issue_id,
                     addr: issue_addr, data: issue_data};

  // core honours full
  a_no_enq_full: assert property (@(posedge clk) disable iff (rst)
    (mem_r || mem_w) |-> !full);

  // memory only answers for live entries still waiting
  a_rsp_live: assert property (@(posedge clk) disable iff (rst)
    mem_rsp.valid |-> (mem_rsp.id < `LSQ_DEPTH) && ent_valid[mem_rsp.id]
                      && !ent_ready[mem_rsp.id]);

  // a retire never drains an empty queue
  a_retire_occ: assert property (@(posedge clk) disable iff (rst)
    ready_out |-> $past(count) != 0);

endmodule

//--- hdl/data_mem_model.sv
// data memory model, word-addressed array with a fixed two-cycle response delay line
`timescale 1ns/1ps
`include "lsq_params.svh"

module data_mem_model (
  input  logic              clk,
  input  logic              rst,
  input  lsq_pkg::mem_req_t mem_req,
  output lsq_pkg::mem_rsp_t mem_rsp
);

  lsq_pkg::word_t mem [`DMEM_WORDS];

  logic [$clog2(`DMEM_WORDS)-1:0] widx; // word index of the request

  // two-stage delay line, several requests may be in flight
  logic [1:0]       pipe_valid;
  lsq_pkg::lsq_id_t pipe_id   [2];
  lsq_pkg::word_t   pipe_data [2];

  assign widx = mem_req.addr[`DMEM_ADDR_LSB +: $clog2(`DMEM_WORDS)];

  // array, word i holds i after reset
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `DMEM_WORDS; i++) begin
        mem[i] <= lsq_pkg::word_t'(i);
      end
    end else if (mem_req.valid && mem_req.rw) begin
      mem[widx] <= mem_req.data; // store lands at the sampling edge
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pipe_valid <= '0;
    end else begin
      pipe_valid <= {pipe_valid[0], mem_req.valid};
    end
  end

  // load reads old contents, store answers with zero
  always_ff @(posedge clk) begin
    pipe_id[0]   <= mem_req.id;
    pipe_data[0] <= mem_req.rw ? '0 : mem[widx];
    pipe_id[1]   <= pipe_id[0];
    pipe_data[1] <= pipe_data[0];
  end

  assign mem_rsp = '{valid: pipe_valid[1], id: pipe_id[1], data: pipe_data[1]};

  // fixed latency, every request answered exactly two cycles later
  a_rsp_latency: assert property (@(posedge clk) disable iff (rst)
    mem_rsp.valid == $past(mem_req.valid, 2));

endmodule

//--- hdl/lsq_mem_top.sv
// load/store queue top, joins the queue to the data memory model
`timescale 1ns/1ps

module lsq_mem_top (
  input  logic               clk,
  input  logic               rst,
  input  logic               mem_r,     // load strobe from core
  input  logic               mem_w,     // store strobe from core
  input  lsq_pkg::core_req_t core_req,
  output lsq_pkg::retire_t   retire,    // valid with ready_out
  output logic               ready_out,
  output logic               full,
  output logic               empty
);

  lsq_pkg::mem_req_t mem_req; // queue -> memory, one request per cycle max
  lsq_pkg::mem_rsp_t mem_rsp; // memory -> queue, tagged by slot id

  // ordering, issue and retirement
  lsq_queue u_queue (
    .clk       (clk),
    .rst       (rst),
    .mem_r     (mem_r),
    .mem_w     (mem_w),
    .core_req  (core_req),
    .mem_rsp   (mem_rsp),
    .mem_req   (mem_req),
    .retire    (retire),
    .ready_out (ready_out),
    .full      (full),
    .empty     (empty)
  );

  // backing store, two cycles request to response
  data_mem_model u_dmem (
    .clk     (clk),
    .rst     (rst),
    .mem_req (mem_req),
    .mem_rsp (mem_rsp)
  );

endmodule

//--- tests/lsq_tb_table.svh
// directed stimulus table for the load/store queue testbench with expected retire data
// columns: op, byte address, store data, wb tag, z tag, expected retire data
// a store retires with its own data, a load with the last older store to its word
// or with the word index when that word was never written

localparam int N_ROWS = 32;

localparam row_t ROWS [N_ROWS] = '{
  // loads to untouched words, data is the word index
  '{OP_LD,   32'h0000_0040, 32'h0000_0000, 4'h1, 4'h0, 32'h0000_0010},
  '{OP_LD,   32'h0000_0080, 32'h0000_0000, 4'h2, 4'h1, 32'h0000_0020},
  '{OP_LD,   32'h0000_00c4, 32'h0000_0000, 4'h3, 4'h2, 32'h0000_0031},
  '{OP_LD,   32'h0000_0ffc, 32'h0000_0000, 4'h4, 4'h3, 32'h0000_03ff}, // last word
  '{OP_IDLE, 32'h0000_0000, 32'h0000_0000, 4'h0, 4'h0, 32'h0000_0000},
  // store then load right behind it, served from the queue
  '{OP_ST,   32'h0000_0100, 32'hdead_beef, 4'h5, 4'h4, 32'hdead_beef},
  '{OP_LD,   32'h0000_0100, 32'h0000_0000, 4'h6, 4'h5, 32'hdead_beef},
  // store left to retire first, load then reads memory
  '{OP_ST,   32'h0000_0200, 32'hcafe_0001, 4'h7, 4'h6, 32'hcafe_0001},
  '{OP_IDLE, 32'h0000_0000, 32'h0000_0000, 4'h0, 4'h0, 32'h0000_0000},
  '{OP_IDLE, 32'h0000_0000, 32'h0000_0000, 4'h0, 4'h0, 32'h0000_0000},
  '{OP_IDLE, 32'h0000_0000, 32'h0000_0000, 4'h0, 4'h0, 32'h0000_0000},
  '{OP_IDLE, 32'h0000_0000, 32'h0000_0000, 4'h0, 4'h0, 32'h0000_0000},
  '{OP_IDLE, 32'h0000_0000, 32'h0000_0000, 4'h0, 4'h0, 32'h0000_0000},
  '{OP_IDLE, 32'h0000_0000, 32'h0000_0000, 4'h0, 4'h0, 32'h0000_0000},
  '{OP_IDLE, 32'h0000_0000, 32'h0000_0000, 4'h0, 4'h0, 32'h0000_0000},
  '{OP_IDLE, 32'h0000_0000, 32'h0000_0000, 4'h0, 4'h0, 32'h0000_0000},
  '{OP_LD,   32'h0000_0200, 32'h0000_0000, 4'h8, 4'h7, 32'hcafe_0001},
  // interleaved traffic over three words
  '{OP_ST,   32'h0000_0010, 32'h1111_1111, 4'h9, 4'h8, 32'h1111_1111},
  '{OP_ST,   32'h0000_0014, 32'h2222_2222, 4'ha, 4'h9, 32'h2222_2222},
  '{OP_LD,   32'h0000_0010, 32'h0000_0000, 4'hb, 4'ha, 32'h1111_1111},
  '{OP_ST,   32'h0000_0010, 32'h3333_3333, 4'hc, 4'hb, 32'h3333_3333},
  '{OP_LD,   32'h0000_0014, 32'h0000_0000, 4'hd, 4'hc, 32'h2222_2222},
  '{OP_LD,   32'h0000_0010, 32'h0000_0000, 4'he, 4'hd, 32'h3333_3333}, // youngest store
  '{OP_LD,   32'h0000_0018, 32'h0000_0000, 4'hf, 4'he, 32'h0000_0006},
  '{OP_ST,   32'h0000_0018, 32'h4444_4444, 4'h0, 4'hf, 32'h4444_4444},
  '{OP_IDLE, 32'h0000_0000, 32'h0000_0000, 4'h0, 4'h0, 32'h0000_0000},
  '{OP_LD,   32'h0000_0018, 32'h0000_0000, 4'h1, 4'h1, 32'h4444_4444},
  '{OP_LD,   32'h0000_0100, 32'h0000_0000, 4'h2, 4'h2, 32'hdead_beef},
  '{OP_IDLE, 32'h0000_0000, 32'h0000_0000, 4'h0, 4'h0, 32'h0000_0000},
  '{OP_IDLE, 32'h0000_0000, 32'h0000_0000, 4'h0, 4'h0, 32'h0000_0000},
  '{OP_LD,   32'h0000_0010, 32'h0000_0000, 4'h3, 4'h3, 32'h3333_3333},
  '{OP_LD,   32'h0000_00c4, 32'h0000_0000, 4'h4, 4'h4, 32'h0000_0031}
};

//--- tests/tb_lsq_mem_top.sv
// testbench for the load/store queue top, directed table, burst and random traffic
`timescale 1ns/1ps
`include "lsq_params.svh"

module tb_lsq_mem_top;

  localparam logic [1:0] OP_IDLE = 2'd0;
  localparam logic [1:0] OP_LD   = 2'd1;
  localparam logic [1:0] OP_ST   = 2'd2;

  localparam int WIDX_W  = $clog2(`DMEM_WORDS); // word index bits
  localparam int N_BURST = `LSQ_DEPTH;
  localparam int N_RAND  = 200;

  typedef struct packed {
    logic [1:0]        op;
    lsq_pkg::word_t    addr;
    lsq_pkg::word_t    data;
    lsq_pkg::reg_tag_t wb;
    lsq_pkg::reg_tag_t z;
    lsq_pkg::word_t    exp_data; // retire data expected for this request
  } row_t;

  `include "lsq_tb_table.svh"

  localparam int N_REQ       = N_ROWS + N_BURST + N_RAND; // idles overcount, harmless
  localparam int CYCLE_LIMIT = 40 * N_REQ + 200;

  logic               clk;
  logic               rst;
  logic               mem_r;
  logic               mem_w;
  lsq_pkg::core_req_t core_req;
  lsq_pkg::retire_t   retire;
  logic               ready_out;
  logic               full;
  logic               empty;

  lsq_pkg::retire_t exp_q [$];                // expected retirements, program order
  lsq_pkg::word_t   shadow [`DMEM_WORDS];     // memory as program order sees it
  int               errors;
  int               sent;                     // requests driven
  int               retired;                  // ready_out pulses seen
  int               cycles;
  int               seed;
  logic             monitor_on;

  lsq_mem_top u_lsq_mem_top (
    .clk       (clk),
    .rst       (rst),
    .mem_r     (mem_r),
    .mem_w     (mem_w),
    .core_req  (core_req),
    .retire    (retire),
    .ready_out (ready_out),
    .full      (full),
    .empty     (empty)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk; // 40 ns period
  end

  task automatic check_bit(input string name, input logic exp, input logic act);
    assert (act === exp) else begin
      errors++;
      $display("error at %0t: %s expected %b got %b", $time, name, exp, act);
    end
  endtask

  task automatic check_word(input string name, input lsq_pkg::word_t exp,
                            input lsq_pkg::word_t act);
    assert (act === exp) else begin
      errors++;
      $display("error at %0t: %s expected %h got %h", $time, name, exp, act);
    end
  endtask

  // program order view of memory, returns what the request should retire with
  function automatic lsq_pkg::word_t model_access(input logic [1:0] op,
                                                  input lsq_pkg::word_t addr,
                                                  input lsq_pkg::word_t data);
    logic [WIDX_W-1:0] w;
    lsq_pkg::word_t    res;
    w   = addr[`DMEM_ADDR_LSB +: WIDX_W];
    res = '0;
    if (op == OP_ST) begin
      shadow[w] = data;
      res       = data; // stores retire with their own data
    end else if (op == OP_LD) begin
      res = shadow[w];
    end
    return res;
  endfunction

  // one request or idle cycle, held off while the queue could fill
  task automatic send(input row_t r);
    @(negedge clk);
    while (full || (sent - retired >= `LSQ_DEPTH)) begin
      @(posedge clk);
      mem_r <= 1'b0;
      mem_w <= 1'b0;
      @(negedge clk);
    end
    @(posedge clk);
    mem_r    <= (r.op == OP_LD);
    mem_w    <= (r.op == OP_ST);
    core_req <= '{addr: r.addr, data: r.data, wb: r.wb, z: r.z};
    if (r.op != OP_IDLE) begin
      exp_q.push_back('{data: r.exp_data, wb: r.wb, z: r.z});
      sent++;
    end
  endtask

  // stop driving and wait for every request to retire
  task automatic drain();
    @(posedge clk);
    mem_r <= 1'b0;
    mem_w <= 1'b0;
    while (retired != sent) @(negedge clk);
    @(negedge clk);
    check_bit("empty", 1'b1, empty);
    check_bit("full", 1'b0, full);
  endtask

  // retire order, data and queue occupancy, sampled mid-cycle
  always @(negedge clk) begin
    lsq_pkg::retire_t exp;
    int               occ;
    if (monitor_on) begin
      if (ready_out) begin
        retired++;
        assert (exp_q.size() != 0) else begin
          errors++;
          $display("ready_out pulsed at %0t with no request left to retire", $time);
        end
        if (exp_q.size() != 0) begin
          exp = exp_q.pop_front();
          check_word("retire.data", exp.data, retire.data);
          check_word("retire.wb", lsq_pkg::word_t'(exp.wb), lsq_pkg::word_t'(retire.wb));
          check_word("retire.z", lsq_pkg::word_t'(exp.z), lsq_pkg::word_t'(retire.z));
        end
      end
      // a request still on the strobes has not been taken yet
      occ = sent - retired - int'(mem_r | mem_w);
      check_bit("full", occ == `LSQ_DEPTH, full);
      check_bit("empty", occ == 0, empty);
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= CYCLE_LIMIT) begin
      errors++;
      $display("run stopped after %0d cycles, requests still outstanding", cycles);
      $display("errors: %0d, retired %0d of %0d requests", errors, retired, sent);
      $display("Testbench failed");
      $finish;
    end
  end

  initial begin
    row_t           r;
    lsq_pkg::word_t exp_model;
    logic [31:0]    rnd;
    errors     = 0;
    sent       = 0;
    retired    = 0;
    cycles     = 0;
    seed       = 22306;
    monitor_on = 1'b0;
    rst      <= 1'b1;
    mem_r    <= 1'b0;
    mem_w    <= 1'b0;
    core_req <= '0;
    for (int i = 0; i < `DMEM_WORDS; i++) begin
      shadow[i] = lsq_pkg::word_t'(i); // memory reset image
    end

    repeat (4) @(posedge clk);
    rst <= 1'b0;
    monitor_on = 1'b1;
    @(negedge clk);
    check_bit("empty", 1'b1, empty);
    check_bit("full", 1'b0, full);
    check_bit("ready_out", 1'b0, ready_out);

    // directed rows, table values cross-checked against the store history
    for (int i = 0; i < N_ROWS; i++) begin
      exp_model = model_access(ROWS[i].op, ROWS[i].addr, ROWS[i].data);
      assert (exp_model == ROWS[i].exp_data) else begin
        errors++;
        $display("table row %0d lists %h but the store history gives %h",
                 i, ROWS[i].exp_data, exp_model);
      end
      send(ROWS[i]);
    end
    drain();

    // fifteen back to back, stores and loads over four words
    // each entry completes within a few cycles so retirement overlaps the burst
    for (int i = 0; i < N_BURST; i++) begin
      r.op       = i[0] ? OP_LD : OP_ST;
      r.addr     = 32'h0000_0300 + 32'(4 * ((i / 2) % 4));
      r.data     = 32'ha5a5_0000 | 32'(i);
      r.wb       = 4'(i);
      r.z        = 4'(15 - i);
      r.exp_data = model_access(r.op, r.addr, r.data);
      send(r);
    end
    drain();

    // random ops over 8 words, some idle cycles
    for (int i = 0; i < N_RAND; i++) begin
      rnd        = $random(seed);
      r.op       = (rnd[1:0] == 2'd0) ? OP_IDLE : (rnd[2] ? OP_ST : OP_LD);
      r.addr     = 32'h0000_0400 | {27'd0, rnd[5:3], 2'b00};
      r.data     = $random(seed);
      r.wb       = rnd[11:8];
      r.z        = rnd[15:12];
      r.exp_data = model_access(r.op, r.addr, r.data);
      send(r);
    end
    drain();

    $display("errors: %0d, retired %0d of %0d requests", errors, retired, sent);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

//--- flist.f
+incdir+hdl
+incdir+tests
hdl/lsq_pkg.sv
hdl/lsq_store_fwd.sv
hdl/lsq_queue.sv
hdl/data_mem_model.sv
hdl/lsq_mem_top.sv
tests/tb_lsq_mem_top.sv

//--- run.sh
#!/bin/sh
# build and run the load/store queue testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f flist.f \
  --top-module tb_lsq_mem_top

./obj_dir/Vtb_lsq_mem_top 2>&1 | tee sim.log

if grep -qx "Testbench passed" sim.log; then
  echo "simulation result: pass"
  exit 0
fi

echo "simulation result: fail, see sim.log"
exit 1
